/* common/board_pkg.sv */
// Board controller package: widths, timing constants, PMU command and power state enums.
package board_pkg;

    // Timing.
    // Core clock cycles between two real-time ticks.
    localparam int TICK_PERIOD = 16;

    // Consecutive high tick samples needed to accept a button press.
    localparam int DEBOUNCE_TICKS = 3;

    // Minimum length of every core reset pulse, in clock cycles.
    localparam int RESET_HOLD_CYCLES = 4;

    // Widths.
    // Ticks since reset, the RTC value seen by the core.
    typedef logic [31:0] tick_count_t;

    // Cycle counter inside the tick timer.
    typedef logic [7:0] tick_div_t;

    // Stability counter of the button debouncer.
    typedef logic [$clog2(DEBOUNCE_TICKS)-1:0] debounce_cnt_t;

    // Core reset hold counter.
    typedef logic [$clog2(RESET_HOLD_CYCLES)-1:0] hold_cnt_t;

    // Power management request from the core.
    // Sampled together with pmu_req while the controller is running.
    typedef enum logic {
        CMD_SHUTDOWN = 1'b0,
        CMD_RESET    = 1'b1
    } pmu_cmd_t;

    // Power FSM states.
    // ST_RESET_HOLD: core held in reset with its clock enabled.
    // ST_RUN:        core running, requests accepted.
    // ST_ACK:        request acknowledged, waiting for req to drop.
    // ST_SHDN:       core clock gated, only the button wakes it.
    typedef enum logic [1:0] {
        ST_RESET_HOLD = 2'd0,
        ST_RUN        = 2'd1,
        ST_ACK        = 2'd2,
        ST_SHDN       = 2'd3
    } power_state_t;

endpackage

/* logic/tick_timer.sv */
// Real-time tick timer: cycle divider, tick pulse and running tick count.
module tick_timer (
    input  logic                   clk,
    input  logic                   reset,
    output logic                   tick,
    output board_pkg::tick_count_t count
);
    import board_pkg::*;

    tick_div_t div;

    // Divider wraps after TICK_PERIOD cycles.
    logic      wrap;

    assign wrap = (div == tick_div_t'(TICK_PERIOD - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            div <= '0;
        end else if (wrap) begin
            div <= '0;
        end else begin
            div <= div + 1'b1;
        end
    end

    // Tick is registered, so it lands on the 16th edge after reset.
    always_ff @(posedge clk) begin
        if (reset) begin
            tick <= 1'b0;
        end else begin
            tick <= wrap;
        end
    end

    // RTC value, advanced together with the tick.
    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (wrap) begin
            count <= count + 1'b1;
        end
    end

endmodule

/* logic/button_debounce.sv */
// Button debouncer: two-flop synchronizer, tick-sampled stability counter, press pulse.
module button_debounce (
    input  logic clk,
    input  logic reset,
    input  logic btn,
    input  logic tick,
    output logic press
);
    import board_pkg::*;

    logic          btn_meta;
    logic          btn_sync;
    debounce_cnt_t cnt;
    logic          stable;
    logic          stable_d;

    // Synchronizer for the asynchronous button.
    always_ff @(posedge clk) begin
        if (reset) begin
            btn_meta <= 1'b0;
            btn_sync <= 1'b0;
        end else begin
            btn_meta <= btn;
            btn_sync <= btn_meta;
        end
    end

    // Button only counts as held after DEBOUNCE_TICKS high samples in a row.
    always_ff @(posedge clk) begin
        if (reset) begin
            cnt    <= '0;
            stable <= 1'b0;
        end else if (tick) begin
            if (!btn_sync) begin
                cnt    <= '0;
                stable <= 1'b0;
            end else if (cnt == debounce_cnt_t'(DEBOUNCE_TICKS - 1)) begin
                stable <= 1'b1;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    // Edge detect on the stable level.
    always_ff @(posedge clk) begin
        if (reset) begin
            stable_d <= 1'b0;
        end else begin
            stable_d <= stable;
        end
    end

    assign press = stable & ~stable_d;

endmodule

/* power/power_fsm.sv */
// Power state machine: core reset and clock enable control, PMU req/ack handshake.
module power_fsm (
    input  logic                clk,
    input  logic                reset,
    input  logic                press,
    input  logic                pmu_req,
    input  board_pkg::pmu_cmd_t pmu_cmd,
    output logic                pmu_ack,
    output logic                core_reset,
    output logic                core_clk_en
);
    import board_pkg::*;

    power_state_t state;
    pmu_cmd_t     cmd_q;
    hold_cnt_t    hold_cnt;

    // Last count value of a reset pulse.
    logic         hold_done;

    assign hold_done = (hold_cnt == hold_cnt_t'(RESET_HOLD_CYCLES - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= ST_RESET_HOLD;
            cmd_q       <= CMD_SHUTDOWN;
            hold_cnt    <= '0;
            pmu_ack     <= 1'b0;
            core_reset  <= 1'b1;
            core_clk_en <= 1'b1;
        end else if (press) begin
            // Button wins over anything the core is doing.
            state       <= ST_RESET_HOLD;
            hold_cnt    <= '0;
            pmu_ack     <= 1'b0;
            core_reset  <= 1'b1;
            core_clk_en <= 1'b1;
        end else begin
            case (state)
                ST_RESET_HOLD: begin
                    if (hold_done) begin
                        state      <= ST_RUN;
                        hold_cnt   <= '0;
                        core_reset <= 1'b0;
                    end else begin
                        hold_cnt <= hold_cnt + 1'b1;
                    end
                end

                ST_RUN: begin
                    if (pmu_req) begin
                        state    <= ST_ACK;
                        cmd_q    <= pmu_cmd;
                        hold_cnt <= '0;
                        pmu_ack  <= 1'b1;
                        if (pmu_cmd == CMD_SHUTDOWN) begin
                            core_clk_en <= 1'b0;
                        end else begin
                            core_reset <= 1'b1;
                        end
                    end
                end

                ST_ACK: begin
                    // Reset pulse keeps counting while the core holds req.
                    if (cmd_q == CMD_RESET && !hold_done) begin
                        hold_cnt <= hold_cnt + 1'b1;
                    end
                    if (!pmu_req) begin
                        pmu_ack <= 1'b0;
                        if (cmd_q == CMD_SHUTDOWN) begin
                            state <= ST_SHDN;
                        end else begin
                            // Finishes the remaining hold cycles, if any.
                            state <= ST_RESET_HOLD;
                        end
                    end
                end

                ST_SHDN: begin
                    // Requests are ignored until a button press.
                    core_clk_en <= 1'b0;
                end

                default: begin
                    state       <= ST_RESET_HOLD;
                    hold_cnt    <= '0;
                    pmu_ack     <= 1'b0;
                    core_reset  <= 1'b1;
                    core_clk_en <= 1'b1;
                end
            endcase
        end
    end

endmodule

/* logic/board_ctrl_top.sv */
// Board controller top level: tick timer, button debouncer and power FSM.
module board_ctrl_top (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   btn,
    input  logic                   pmu_req,
    input  board_pkg::pmu_cmd_t    pmu_cmd,
    output logic                   pmu_ack,
    output logic                   core_reset,
    output logic                   core_clk_en,
    output logic                   rtc_tick,
    output board_pkg::tick_count_t rtc_count
);

    // Debounced button press, one cycle wide.
    logic press;

    // The RTC tick doubles as the debounce sample strobe.
    tick_timer tick_timer_i (
        .clk   (clk),
        .reset (reset),
        .tick  (rtc_tick),
        .count (rtc_count)
    );

    button_debounce button_debounce_i (
        .clk   (clk),
        .reset (reset),
        .btn   (btn),
        .tick  (rtc_tick),
        .press (press)
    );

    power_fsm power_fsm_i (
        .clk         (clk),
        .reset       (reset),
        .press       (press),
        .pmu_req     (pmu_req),
        .pmu_cmd     (pmu_cmd),
        .pmu_ack     (pmu_ack),
        .core_reset  (core_reset),
        .core_clk_en (core_clk_en)
    );

endmodule

/* test/board_ctrl_tasks.svh */
// Directed board controller tests with their check, request and timed-wait helpers.
`ifndef BOARD_CTRL_TASKS_SVH
`define BOARD_CTRL_TASKS_SVH

task automatic expect_value(input string name, input logic [63:0] actual,
                            input logic [63:0] expected);
    check_count++;
    assert (actual === expected) else begin
        $display("[ERROR] t=%0t %s: expected %0d, got %0d", $time, name, expected, actual);
        error_count++;
    end
endtask

task automatic idle_gap();
    repeat ($urandom % 11) @(negedge clk);
endtask

// Moves past the current cycle, then waits for the next tick pulse.
task automatic wait_tick(output int at_cycle);
    int guard;
    guard = 0;
    @(negedge clk);
    while (rtc_tick !== 1'b1 && guard < TIMEOUT_CYCLES) begin
        @(negedge clk);
        guard++;
    end
    if (rtc_tick !== 1'b1) begin
        $display("Timeout: no rtc_tick pulse within %0d cycles", TIMEOUT_CYCLES);
        timeout_count++;
    end
    at_cycle = cycle_cnt;
endtask

// Counts the cycles core_reset stays high, starting with the current one.
task automatic count_reset_high(output int high);
    high = 0;
    while (core_reset === 1'b1 && high < TIMEOUT_CYCLES) begin
        expect_value("core_clk_en", core_clk_en, 1);
        high++;
        @(negedge clk);
    end
    if (core_reset === 1'b1) begin
        $display("Timeout: core_reset still high after %0d cycles", TIMEOUT_CYCLES);
        timeout_count++;
    end
endtask

task automatic raise_request(input pmu_cmd_t cmd);
    pmu_cmd = cmd;
    pmu_req = 1'b1;
    @(negedge clk);
    expect_value("pmu_ack", pmu_ack, 1);
    if (cmd == CMD_SHUTDOWN) begin
        expect_value("core_clk_en", core_clk_en, 0);
    end else begin
        expect_value("core_reset", core_reset, 1);
    end
endtask

task automatic drop_request();
    pmu_req = 1'b0;
    @(negedge clk);
    expect_value("pmu_ack", pmu_ack, 0);
endtask

task automatic tick_spacing(input int pulses);
    int last_cycle;
    int now_cycle;
    tick_count_t last_count;
    wait_tick(last_cycle);
    last_count = rtc_count;
    for (int i = 0; i < pulses; i++) begin
        wait_tick(now_cycle);
        expect_value("rtc_tick spacing", now_cycle - last_cycle, TICK_PERIOD);
        expect_value("rtc_count", rtc_count, last_count + 1);
        last_cycle = now_cycle;
        last_count = rtc_count;
    end
endtask

task automatic reset_release();
    for (int i = 0; i < RESET_HOLD_CYCLES; i++) begin
        expect_value("core_reset", core_reset, 1);
        expect_value("core_clk_en", core_clk_en, 1);
        expect_value("pmu_ack", pmu_ack, 0);
        @(negedge clk);
    end
    expect_value("core_reset", core_reset, 0);
    expect_value("core_clk_en", core_clk_en, 1);
endtask

task automatic rtc_tick_run();
    int at_cycle;
    wait_tick(at_cycle);
    expect_value("first rtc_tick cycle", at_cycle, TICK_PERIOD);
    expect_value("rtc_count", rtc_count, 1);
    tick_spacing(3);
endtask

task automatic shutdown_request();
    int hold;
    int guard;
    hold = $urandom % 8;
    raise_request(CMD_SHUTDOWN);
    repeat (hold) begin
        @(negedge clk);
        expect_value("pmu_ack", pmu_ack, 1);
    end
    drop_request();
    expect_value("core_clk_en", core_clk_en, 0);
    tick_spacing(2);
    // A request while shut down must stay unanswered.
    pmu_cmd = CMD_RESET;
    pmu_req = 1'b1;
    guard = 0;
    while (pmu_ack !== 1'b1 && guard < 50) begin
        @(negedge clk);
        guard++;
    end
    expect_value("pmu_ack", pmu_ack, 0);
    expect_value("core_clk_en", core_clk_en, 0);
    pmu_req = 1'b0;
endtask

task automatic short_button();
    btn = 1'b1;
    for (int i = 0; i < 100; i++) begin
        if (i == TICK_PERIOD) begin
            btn = 1'b0;
        end
        @(negedge clk);
        expect_value("core_reset", core_reset, 0);
        expect_value("core_clk_en", core_clk_en, 0);
    end
endtask

task automatic button_wake();
    int held;
    int high;
    btn = 1'b1;
    held = 0;
    while (core_reset !== 1'b1 && held < 5 * TICK_PERIOD) begin
        @(negedge clk);
        held++;
    end
    if (core_reset !== 1'b1) begin
        $display("Timeout: button press did not raise core_reset");
        timeout_count++;
    end
    count_reset_high(high);
    expect_value("core_reset high cycles", high, RESET_HOLD_CYCLES);
    expect_value("core_clk_en", core_clk_en, 1);
    held += high;
    // Button stays down for the rest of the five tick periods.
    while (held < 5 * TICK_PERIOD) begin
        @(negedge clk);
        held++;
    end
    btn = 1'b0;
    raise_request(CMD_RESET);
    drop_request();
    count_reset_high(high);
endtask

task automatic reset_request();
    int hold;
    int high;
    int rest;
    // Short enough that the controller has to stretch the reset pulse.
    hold = $urandom % (RESET_HOLD_CYCLES - 1);
    raise_request(CMD_RESET);
    high = 1;
    repeat (hold) begin
        @(negedge clk);
        expect_value("pmu_ack", pmu_ack, 1);
        expect_value("core_reset", core_reset, 1);
        high++;
    end
    drop_request();
    count_reset_high(rest);
    high += rest;
    check_count++;
    assert (high >= RESET_HOLD_CYCLES) else begin
        $display("[ERROR] t=%0t core_reset high cycles: expected at least %0d, got %0d",
                 $time, RESET_HOLD_CYCLES, high);
        error_count++;
    end
    expect_value("core_reset", core_reset, 0);
    expect_value("core_clk_en", core_clk_en, 1);
    raise_request(CMD_SHUTDOWN);
    drop_request();
    expect_value("core_clk_en", core_clk_en, 0);
endtask

`endif

/* test/board_ctrl_tb.sv */
// Testbench top: clock, reset, board controller DUT, error counters and test sequence.
module board_ctrl_tb;
    import board_pkg::*;

    localparam int CLK_PERIOD     = 100;
    localparam int RESET_CYCLES   = 3;
    localparam int TIMEOUT_CYCLES = 200;

    logic        clk;
    logic        reset;
    logic        btn;
    logic        pmu_req;
    pmu_cmd_t    pmu_cmd;
    logic        pmu_ack;
    logic        core_reset;
    logic        core_clk_en;
    logic        rtc_tick;
    tick_count_t rtc_count;

    // Rising edges since reset fell.
    int cycle_cnt;
    int check_count;
    int error_count;
    int timeout_count;

    board_ctrl_top dut_i (
        .clk         (clk),
        .reset       (reset),
        .btn         (btn),
        .pmu_req     (pmu_req),
        .pmu_cmd     (pmu_cmd),
        .pmu_ack     (pmu_ack),
        .core_reset  (core_reset),
        .core_clk_en (core_clk_en),
        .rtc_tick    (rtc_tick),
        .rtc_count   (rtc_count)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        if (reset) begin
            cycle_cnt <= 0;
        end else begin
            cycle_cnt <= cycle_cnt + 1;
        end
    end

    `include "board_ctrl_tasks.svh"

    initial begin
        void'($urandom(32'hbac7));
        check_count   = 0;
        error_count   = 0;
        timeout_count = 0;
        reset   = 1'b1;
        btn     = 1'b0;
        pmu_req = 1'b0;
        pmu_cmd = CMD_SHUTDOWN;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        expect_value("rtc_tick", rtc_tick, 0);
        expect_value("rtc_count", rtc_count, 0);
        reset = 1'b0;

        reset_release();
        rtc_tick_run();
        idle_gap();
        shutdown_request();
        idle_gap();
        short_button();
        idle_gap();
        button_wake();
        idle_gap();
        reset_request();

        $display("Checks: %0d, errors: %0d, timeouts: %0d",
                 check_count, error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* filelist.f */
+incdir+test
common/board_pkg.sv
logic/tick_timer.sv
logic/button_debounce.sv
power/power_fsm.sv
logic/board_ctrl_top.sv
test/board_ctrl_tb.sv

/* Makefile */
TOP = board_ctrl_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --top-module board_ctrl_top \
		common/board_pkg.sv logic/tick_timer.sv logic/button_debounce.sv \
		power/power_fsm.sv logic/board_ctrl_top.sv

sim:
	verilator --binary --timing --assert -Wno-fatal -f filelist.f \
		--top-module $(TOP) -Mdir obj_dir
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir
